// ==== tb.f ====
fetch_pkg.sv
fetch_out_if.sv
prefetch_unit.sv
compressed_decoder.sv
if_stage.sv
if_stage_checker.sv
tb_if_stage.sv

// ==== tb_if_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench top of the fetch stage. Bus memory model, redirect command
// table applied in a loop, scoreboard instance and cycle limit
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_if_stage;
  import fetch_pkg::*;

  localparam int IMG_N          = 11;
  localparam int CMD_N          = 7;
  localparam int TIMEOUT_CYCLES = CMD_N * 200;

  // One redirect with its stall patterns and expected target
  typedef struct packed {
    logic [7:0]  delay;
    logic [7:0]  n_instr;
    pc_mux_e     pc_mux;
    exc_pc_mux_e exc_mux;
    logic [4:0]  irq_id;
    logic [7:0]  halt_pat;
    logic [7:0]  ready_pat;
    logic [31:0] target;
  } cmd_t;

  logic                   clk;
  logic                   rst_n;
  logic                   pc_set_i;
  pc_mux_e                pc_mux_i;
  exc_pc_mux_e            exc_pc_mux_i;
  logic [4:0]             irq_id_i;
  logic [23:0]            mtvec_addr_i;
  logic [31:0]            boot_addr_i;
  logic [31:0]            nmi_addr_i;
  logic [31:0]            mepc_i;
  logic [31:0]            jump_target_i;
  logic                   halt_if_i;
  logic                   kill_if_i;
  logic                   id_ready_i;
  logic                   instr_req_o;
  logic [31:0]            instr_addr_o;
  logic                   instr_gnt_i;
  logic                   instr_rvalid_i;
  logic [31:0]            instr_rdata_i;
  logic                   if_valid_o;
  logic [31:0]            pc_if_o;
  logic                   if_busy_o;
  logic                   csr_mtvec_init_o;
  logic                   id_instr_valid_o;
  logic [31:0]            id_instr_o;
  logic [31:0]            id_pc_o;
  logic                   id_compressed_o;
  logic                   id_illegal_c_o;

  // Memory image, word address / stored word / expanded word / illegal
  logic [IMG_N-1:0][31:0] img_addr;
  logic [IMG_N-1:0][31:0] img_word;
  logic [IMG_N-1:0][31:0] img_exp;
  logic [IMG_N-1:0]       img_ill;

  cmd_t                   cmds [CMD_N];
  int                     cmd_idx;
  logic [31:0]            exp_target;
  logic [7:0]             halt_pat;
  logic [7:0]             ready_pat;
  logic [2:0]             phase;
  int unsigned            cycle_cnt = 0;
  int                     err_count;
  int                     check_count;
  int                     seg_count;

  // Accepted reads waiting for their response
  logic [31:0]            resp_addr_q [$];
  int unsigned            resp_due_q [$];
  int unsigned            stall;

  if_stage dut_i (.*);

  if_stage_checker #(
    .IMG_N (IMG_N)
  ) u_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .pc_set_i        (pc_set_i),
    .pc_mux_i        (pc_mux_i),
    .halt_if_i       (halt_if_i),
    .kill_if_i       (kill_if_i),
    .id_ready_i      (id_ready_i),
    .instr_req_i     (instr_req_o),
    .instr_addr_i    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .if_valid_i      (if_valid_o),
    .pc_if_i         (pc_if_o),
    .if_busy_i       (if_busy_o),
    .mtvec_init_i    (csr_mtvec_init_o),
    .id_valid_i      (id_instr_valid_o),
    .id_instr_i      (id_instr_o),
    .id_pc_i         (id_pc_o),
    .id_compressed_i (id_compressed_o),
    .id_illegal_i    (id_illegal_c_o),
    .exp_target_i    (exp_target),
    .img_addr_i      (img_addr),
    .img_word_i      (img_word),
    .img_exp_i       (img_exp),
    .img_ill_i       (img_ill),
    .err_count_o     (err_count),
    .check_count_o   (check_count),
    .seg_count_o     (seg_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic set_image(input int idx, input logic [31:0] addr, input logic [31:0] word,
                           input logic [31:0] expanded, input logic illegal);
    img_addr[idx] = addr;
    img_word[idx] = word;
    img_exp[idx]  = expanded;
    img_ill[idx]  = illegal;
  endtask

  function automatic logic [31:0] image_word(input logic [31:0] addr);
    logic [31:0] word;
    int          k;
    word = INSTR_NOP;
    for (k = 0; k < IMG_N; k++)
    begin
      if (img_addr[k] == addr)
      begin
        word = img_word[k];
      end
    end
    return word;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model, grant after 0 to 2 stall cycles, reply 1 to 2 cycles later
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (instr_req_o && instr_gnt_i)
      begin
        resp_addr_q.push_back(instr_addr_o);
        resp_due_q.push_back(cycle_cnt + ($urandom % 2));
        stall = $urandom % 3;
      end
      else if (stall > 0)
      begin
        stall = stall - 1;
      end
      instr_gnt_i <= (stall == 0);
      // At most one response per cycle, in order
      if ((resp_due_q.size() > 0) && (resp_due_q[0] <= cycle_cnt))
      begin
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= image_word(resp_addr_q[0]);
        void'(resp_addr_q.pop_front());
        void'(resp_due_q.pop_front());
      end
      else
      begin
        instr_rvalid_i <= 1'b0;
      end
    end
  end

  // Halt and decode stall patterns, a zero ready bit means random
  always @(posedge clk)
  begin
    if (rst_n)
    begin
      halt_if_i  <= halt_pat[phase];
      id_ready_i <= ready_pat[phase] ? 1'b1 : ($urandom % 2 == 1);
      phase      <= phase + 3'd1;
    end
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES)
    begin
      $display("Timeout after %0d cycles, the fetch stream hung", cycle_cnt);
      $display("Some tests failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    void'($urandom(72));
    rst_n          = 1'b0;
    pc_set_i       = 1'b0;
    pc_mux_i       = PC_BOOT;
    exc_pc_mux_i   = EXC_PC_EXCEPTION;
    irq_id_i       = 5'd0;
    mtvec_addr_i   = 24'h000001;
    boot_addr_i    = 32'h0000_0080;
    nmi_addr_i     = 32'h0000_0300;
    mepc_i         = 32'h0000_0202;
    jump_target_i  = 32'h0000_0096;
    halt_if_i      = 1'b0;
    kill_if_i      = 1'b0;
    id_ready_i     = 1'b1;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    exp_target     = '0;
    halt_pat       = 8'h00;
    ready_pat      = 8'hFF;
    phase          = 3'd0;
    stall          = 0;

    // 32-bit words, then c.li c.addi c.lw c.sw c.mv c.add, zero, c.j, c.addi16sp
    set_image(0,  32'h080, 32'h0050_0093, 32'h0050_0093, 1'b0);
    set_image(1,  32'h084, 32'h0000_451D, 32'h0070_0513, 1'b0);
    set_image(2,  32'h088, 32'h0000_157D, 32'hFFF5_0513, 1'b0);
    set_image(3,  32'h08C, 32'h0000_4044, 32'h0044_2483, 1'b0);
    set_image(4,  32'h090, 32'h0000_C404, 32'h0094_2423, 1'b0);
    set_image(5,  32'h094, 32'h0000_85AA, 32'h00A0_05B3, 1'b0);
    set_image(6,  32'h098, 32'h0000_95AA, 32'h00A5_85B3, 1'b0);
    set_image(7,  32'h09C, 32'h0000_0000, 32'h0000_0013, 1'b1);
    set_image(8,  32'h0A0, 32'h0000_A801, 32'h0100_006F, 1'b0);
    set_image(9,  32'h0A4, 32'h0000_6105, 32'h0000_0013, 1'b1);
    set_image(10, 32'h114, 32'h00A2_8293, 32'h00A2_8293, 1'b0);

    // delay, count, source, trap kind, irq, halt, ready, target
    cmds[0] = '{8'd2, 8'd10, PC_BOOT, EXC_PC_EXCEPTION, 5'd0, 8'h00, 8'hFF, 32'h080};
    cmds[1] = '{8'd3, 8'd4, PC_JUMP, EXC_PC_EXCEPTION, 5'd0, 8'h00, 8'hFF, 32'h094};
    cmds[2] = '{8'd1, 8'd3, PC_MRET, EXC_PC_EXCEPTION, 5'd0, 8'h00, 8'hFF, 32'h200};
    cmds[3] = '{8'd2, 8'd3, PC_NMI, EXC_PC_EXCEPTION, 5'd0, 8'h00, 8'hFF, 32'h300};
    cmds[4] = '{8'd1, 8'd3, PC_EXCEPTION, EXC_PC_EXCEPTION, 5'd0, 8'h00, 8'hFF, 32'h100};
    cmds[5] = '{8'd2, 8'd3, PC_EXCEPTION, EXC_PC_IRQ, 5'd5, 8'h00, 8'hFF, 32'h114};
    cmds[6] = '{8'd1, 8'd10, PC_BOOT, EXC_PC_EXCEPTION, 5'd0, 8'h30, 8'hA5, 32'h080};

    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    for (cmd_idx = 0; cmd_idx < CMD_N; cmd_idx++)
    begin
      repeat (cmds[cmd_idx].delay) @(posedge clk);
      halt_pat     <= cmds[cmd_idx].halt_pat;
      ready_pat    <= cmds[cmd_idx].ready_pat;
      pc_mux_i     <= cmds[cmd_idx].pc_mux;
      exc_pc_mux_i <= cmds[cmd_idx].exc_mux;
      irq_id_i     <= cmds[cmd_idx].irq_id;
      exp_target   <= cmds[cmd_idx].target;
      // Kill rides along with the redirect
      pc_set_i     <= 1'b1;
      kill_if_i    <= 1'b1;
      @(posedge clk);
      pc_set_i     <= 1'b0;
      kill_if_i    <= 1'b0;
      @(posedge clk);
      while (seg_count < int'(cmds[cmd_idx].n_instr))
      begin
        @(posedge clk);
      end
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    $display("Checks: %0d, errors: %0d", check_count, err_count);
    if (err_count == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// ==== if_stage_checker.sv ====
////////////////////////////////////////////////////////////////////////////
// Scoreboard of the fetch stage testbench. Watches the DUT ports and
// predicts the IF/ID stream from the memory image and redirect targets
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage_checker #(
  parameter int IMG_N = 1
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         pc_set_i,
  input  fetch_pkg::pc_mux_e           pc_mux_i,
  input  logic                         halt_if_i,
  input  logic                         kill_if_i,
  input  logic                         id_ready_i,
  input  logic                         instr_req_i,
  input  logic [31:0]                  instr_addr_i,
  input  logic                         instr_gnt_i,
  input  logic                         instr_rvalid_i,
  input  logic                         if_valid_i,
  input  logic [31:0]                  pc_if_i,
  input  logic                         if_busy_i,
  input  logic                         mtvec_init_i,
  input  logic                         id_valid_i,
  input  logic [31:0]                  id_instr_i,
  input  logic [31:0]                  id_pc_i,
  input  logic                         id_compressed_i,
  input  logic                         id_illegal_i,
  // Target of the redirect in flight
  input  logic [31:0]                  exp_target_i,
  // Memory image
  input  logic [IMG_N-1:0][31:0]       img_addr_i,
  input  logic [IMG_N-1:0][31:0]       img_word_i,
  input  logic [IMG_N-1:0][31:0]       img_exp_i,
  input  logic [IMG_N-1:0]             img_ill_i,
  output int                           err_count_o,
  output int                           check_count_o,
  output int                           seg_count_o
);
  import fetch_pkg::*;

  logic        started;
  logic [31:0] next_pc;
  logic        pend;
  logic [31:0] pend_pc;
  logic        bubble;
  logic        hold;
  logic        hold_valid;
  logic [31:0] hold_instr;
  logic [31:0] hold_pc;
  logic        hold_comp;
  logic        hold_ill;
  logic [33:0] entry;
  int          reads_out;

  initial
  begin
    err_count_o   = 0;
    check_count_o = 0;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count_o++;
    if (expected !== actual)
    begin
      err_count_o++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string what);
    err_count_o++;
    $display("%0t: %s", $time, what);
  endtask

  // {illegal, compressed, expanded word}, words outside the image read as NOP
  function automatic logic [33:0] expect_entry(input logic [31:0] addr);
    logic [33:0] result;
    int          k;
    result = {2'b00, INSTR_NOP};
    for (k = 0; k < IMG_N; k++)
    begin
      if (img_addr_i[k] == addr)
      begin
        result = {img_ill_i[k], img_word_i[k][1:0] != 2'b11, img_exp_i[k]};
      end
    end
    return result;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Checks on sampled values, all taken at the rising edge
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      if (instr_req_i || if_valid_i || id_valid_i || if_busy_i || mtvec_init_i)
      begin
        report_failure("fetch stage outputs active during reset");
      end
      started     <= 1'b0;
      pend        <= 1'b0;
      bubble      <= 1'b0;
      hold        <= 1'b0;
      reads_out   <= 0;
      seg_count_o <= 0;
    end
    else
    begin
      // Register loaded by last cycle's transfer
      if (pend)
      begin
        entry = expect_entry(pend_pc);
        check_value("id_instr_valid_o", 32'd1, {31'd0, id_valid_i});
        check_value("id_pc_o", pend_pc, id_pc_i);
        check_value("id_instr_o", entry[31:0], id_instr_i);
        check_value("id_compressed_o", {31'd0, entry[32]}, {31'd0, id_compressed_i});
        check_value("id_illegal_c_o", {31'd0, entry[33]}, {31'd0, id_illegal_i});
        seg_count_o <= seg_count_o + 1;
      end
      if (bubble)
      begin
        check_value("id_instr_valid_o", 32'd0, {31'd0, id_valid_i});
      end
      // Decode stalled, nothing may move
      if (hold)
      begin
        check_value("id_instr_valid_o", {31'd0, hold_valid}, {31'd0, id_valid_i});
        check_value("id_instr_o", hold_instr, id_instr_i);
        check_value("id_pc_o", hold_pc, id_pc_i);
        check_value("id_compressed_o", {31'd0, hold_comp}, {31'd0, id_compressed_i});
        check_value("id_illegal_c_o", {31'd0, hold_ill}, {31'd0, id_illegal_i});
      end

      pend       <= if_valid_i && id_ready_i;
      bubble     <= id_ready_i && !if_valid_i;
      hold       <= !id_ready_i;
      hold_valid <= id_valid_i;
      hold_instr <= id_instr_i;
      hold_pc    <= id_pc_i;
      hold_comp  <= id_compressed_i;
      hold_ill   <= id_illegal_i;

      // Stream stays in order with no gaps
      if (if_valid_i && id_ready_i)
      begin
        check_value("pc_if_o", next_pc, pc_if_i);
        pend_pc <= next_pc;
        next_pc <= next_pc + 32'd4;
      end
      if (halt_if_i && if_valid_i)
      begin
        report_failure("instruction offered to decode while halted");
      end
      if (kill_if_i && if_valid_i)
      begin
        report_failure("instruction offered to decode while killed");
      end
      if (instr_req_i && !started)
      begin
        report_failure("bus request before the first redirect");
      end
      if (instr_req_i)
      begin
        check_value("instr_addr_o[1:0]", 32'd0, {30'd0, instr_addr_i[1:0]});
      end

      // Busy follows reads granted on the bus and not yet answered
      check_value("if_busy_o", {31'd0, reads_out != 0}, {31'd0, if_busy_i});
      reads_out <= reads_out + int'(instr_req_i && instr_gnt_i) - int'(instr_rvalid_i);

      check_value("csr_mtvec_init_o", {31'd0, pc_set_i && (pc_mux_i == PC_BOOT)},
                  {31'd0, mtvec_init_i});

      // New stream starts at the redirect target
      if (pc_set_i)
      begin
        started     <= 1'b1;
        next_pc     <= exp_target_i;
        seg_count_o <= 0;
      end
    end
  end

endmodule

// ==== if_stage.sv ====
////////////////////////////////////////////////////////////////////////////
// Instruction fetch stage top. PC selection, prefetch, expansion and the
// IF/ID register that holds while decode stalls
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module if_stage (
  input  logic                          clk,
  input  logic                          rst_n,

  // Redirect control
  input  logic                          pc_set_i,
  input  fetch_pkg::pc_mux_e            pc_mux_i,
  input  fetch_pkg::exc_pc_mux_e        exc_pc_mux_i,
  input  logic [4:0]                    irq_id_i,

  // Redirect addresses
  input  logic [23:0]                   mtvec_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    nmi_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]    jump_target_i,

  // Stage control
  input  logic                          halt_if_i,
  input  logic                          kill_if_i,
  input  logic                          id_ready_i,

  // Instruction bus
  output logic                          instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]    instr_addr_o,
  input  logic                          instr_gnt_i,
  input  logic                          instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]    instr_rdata_i,

  // Status
  output logic                          if_valid_o,
  output logic [fetch_pkg::XLEN-1:0]    pc_if_o,
  output logic                          if_busy_o,
  output logic                          csr_mtvec_init_o,

  // IF/ID register
  output logic                          id_instr_valid_o,
  output logic [fetch_pkg::XLEN-1:0]    id_instr_o,
  output logic [fetch_pkg::XLEN-1:0]    id_pc_o,
  output logic                          id_compressed_o,
  output logic                          id_illegal_c_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] exc_pc;
  logic [XLEN-1:0] branch_addr;
  logic [XLEN-1:0] instr_expanded;
  logic            instr_compressed;
  logic            illegal_c;
  if_id_pipe_t     if_id_q;

  fetch_out_if pf_if ();

  ////////////////////////////////////////////////////////////////////////////
  // Redirect address
  ////////////////////////////////////////////////////////////////////////////

  // Exceptions use the mtvec base, interrupts are vectored by id
  always_comb
  begin
    unique case (exc_pc_mux_i)
      EXC_PC_IRQ: exc_pc = {mtvec_addr_i, 1'b0, irq_id_i, 2'b00};
      default:    exc_pc = {mtvec_addr_i, 8'h00};
    endcase
  end

  always_comb
  begin
    unique case (pc_mux_i)
      PC_JUMP:      branch_addr = jump_target_i;
      PC_EXCEPTION: branch_addr = exc_pc;
      PC_MRET:      branch_addr = mepc_i;
      PC_NMI:       branch_addr = nmi_addr_i;
      default:      branch_addr = boot_addr_i;
    endcase
  end

  // mtvec gets its reset value on the boot redirect
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  prefetch_unit u_prefetch (
    .clk             (clk),
    .rst_n           (rst_n),
    .redirect_i      (pc_set_i),
    .redirect_addr_i ({branch_addr[XLEN-1:2], 2'b00}),
    .req_o           (instr_req_o),
    .addr_o          (instr_addr_o),
    .gnt_i           (instr_gnt_i),
    .rvalid_i        (instr_rvalid_i),
    .rdata_i         (instr_rdata_i),
    .busy_o          (if_busy_o),
    .out             (pf_if.producer)
  );

  compressed_decoder u_c_dec (
    .instr_i         (pf_if.instr),
    .instr_o         (instr_expanded),
    .is_compressed_o (instr_compressed),
    .illegal_o       (illegal_c)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Handshake and IF/ID register
  ////////////////////////////////////////////////////////////////////////////

  // Kill consumes the head entry without passing it on
  assign if_valid_o  = pf_if.valid && !halt_if_i && !kill_if_i;
  assign pf_if.ready = kill_if_i || (id_ready_i && !halt_if_i);
  assign pc_if_o     = pf_if.addr;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      if_id_q.instr_valid <= 1'b0;
      if_id_q.instr       <= INSTR_NOP;
      if_id_q.pc          <= '0;
      if_id_q.compressed  <= 1'b0;
      if_id_q.illegal_c   <= 1'b0;
    end
    else if (if_valid_o && id_ready_i)
    begin
      if_id_q.instr_valid <= 1'b1;
      if_id_q.instr       <= instr_expanded;
      if_id_q.pc          <= pf_if.addr;
      if_id_q.compressed  <= instr_compressed;
      if_id_q.illegal_c   <= illegal_c;
    end
    else if (id_ready_i)
    begin
      // Bubble into decode, payload kept
      if_id_q.instr_valid <= 1'b0;
    end
  end

  assign id_instr_valid_o = if_id_q.instr_valid;
  assign id_instr_o       = if_id_q.instr;
  assign id_pc_o          = if_id_q.pc;
  assign id_compressed_o  = if_id_q.compressed;
  assign id_illegal_c_o   = if_id_q.illegal_c;

  // Redirect is a single-cycle pulse from the controller
  a_pc_set_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    pc_set_i |=> !pc_set_i
  );

endmodule

// ==== compressed_decoder.sv ====
////////////////////////////////////////////////////////////////////////////
// Expands the supported RV32C subset to RV32I words, flags the rest
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module compressed_decoder (
  input  logic [fetch_pkg::XLEN-1:0] instr_i,
  output logic [fetch_pkg::XLEN-1:0] instr_o,
  output logic                     is_compressed_o,
  output logic                     illegal_o
);
  import fetch_pkg::*;

  always_comb
  begin
    instr_o   = instr_i;
    illegal_o = 1'b0;

    unique case (instr_i[1:0])
      // Quadrant 0
      2'b00:
      begin
        unique case (instr_i[15:13])
          // c.lw -> lw rd', imm(rs1')
          3'b010:
            instr_o = {5'b0, instr_i[5], instr_i[12:10], instr_i[6], 2'b00,
                       2'b01, instr_i[9:7], 3'b010, 2'b01, instr_i[4:2], 7'b0000011};
          // c.sw -> sw rs2', imm(rs1')
          3'b110:
            instr_o = {5'b0, instr_i[5], instr_i[12], 2'b01, instr_i[4:2],
                       2'b01, instr_i[9:7], 3'b010, instr_i[11:10], instr_i[6],
                       2'b00, 7'b0100011};
          // Includes c.addi4spn and the all-zero halfword
          default:
            illegal_o = 1'b1;
        endcase
      end

      // Quadrant 1
      2'b01:
      begin
        unique case (instr_i[15:13])
          // c.addi -> addi rd, rd, imm
          3'b000:
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], instr_i[11:7],
                       3'b000, instr_i[11:7], 7'b0010011};
          // c.li -> addi rd, x0, imm
          3'b010:
            instr_o = {{6{instr_i[12]}}, instr_i[12], instr_i[6:2], 5'b0,
                       3'b000, instr_i[11:7], 7'b0010011};
          // c.j -> jal x0, offset
          3'b101:
            instr_o = {instr_i[12], instr_i[8], instr_i[10:9], instr_i[6],
                       instr_i[7], instr_i[2], instr_i[11], instr_i[5:3],
                       instr_i[12], {8{instr_i[12]}}, 5'b0, 7'b1101111};
          default:
            illegal_o = 1'b1;
        endcase
      end

      // Quadrant 2
      2'b10:
      begin
        // rs2 == 0 would be jr, jalr or ebreak, not supported here
        if ((instr_i[15:13] == 3'b100) && (instr_i[6:2] != 5'b0))
        begin
          if (instr_i[12])
          begin
            // c.add -> add rd, rd, rs2
            instr_o = {7'b0, instr_i[6:2], instr_i[11:7], 3'b000, instr_i[11:7],
                       7'b0110011};
          end
          else
          begin
            // c.mv -> add rd, x0, rs2
            instr_o = {7'b0, instr_i[6:2], 5'b0, 3'b000, instr_i[11:7], 7'b0110011};
          end
        end
        else
        begin
          illegal_o = 1'b1;
        end
      end

      // Full-width instruction passes unchanged
      default:;
    endcase

    if (illegal_o)
    begin
      instr_o = INSTR_NOP;
    end
  end

  assign is_compressed_o = (instr_i[1:0] != 2'b11);

endmodule

// ==== prefetch_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Word fetcher on the req/gnt instruction bus with a small response FIFO.
// A redirect flushes the FIFO and drops reads still in flight
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module prefetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,

  // New fetch address, one-cycle pulse
  input  logic                     redirect_i,
  input  logic [fetch_pkg::XLEN-1:0] redirect_addr_i,

  // Instruction bus
  output logic                     req_o,
  output logic [fetch_pkg::XLEN-1:0] addr_o,
  input  logic                     gnt_i,
  input  logic                     rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,

  // High while any read is in flight
  output logic                     busy_o,

  fetch_out_if.producer            out
);
  import fetch_pkg::*;

  logic [XLEN-1:0]  fetch_addr_q;
  logic [XLEN-1:0]  resp_addr_q;
  logic             started_q;
  logic [CNT_W-1:0] outstanding_q;
  logic [CNT_W-1:0] discard_q;
  logic [CNT_W-1:0] count_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W:0]   occupancy;
  logic             issue;
  logic             push;
  logic             pop;

  // Buffered responses and their word addresses
  logic [XLEN-1:0]  instr_mem [PF_DEPTH];
  logic [XLEN-1:0]  addr_mem  [PF_DEPTH];

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(PF_DEPTH - 1))
    begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  // Reads in flight plus buffered words must leave room for one more
  assign occupancy = {1'b0, outstanding_q} + {1'b0, count_q};
  assign req_o     = started_q && !redirect_i && (occupancy < (CNT_W + 1)'(PF_DEPTH));
  assign addr_o    = fetch_addr_q;
  assign issue     = req_o && gnt_i;
  assign busy_o    = (outstanding_q != '0);

  // Stale responses are dropped, as is one arriving with the redirect
  assign push = rvalid_i && (discard_q == '0) && !redirect_i;
  assign pop  = out.valid && out.ready;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      started_q     <= 1'b0;
      fetch_addr_q  <= '0;
      resp_addr_q   <= '0;
      outstanding_q <= '0;
      discard_q     <= '0;
    end
    else
    begin
      outstanding_q <= outstanding_q + CNT_W'(issue) - CNT_W'(rvalid_i);
      if (redirect_i)
      begin
        started_q    <= 1'b1;
        fetch_addr_q <= redirect_addr_i;
        resp_addr_q  <= redirect_addr_i;
        // Everything still on the bus belongs to the old stream
        discard_q    <= outstanding_q - CNT_W'(rvalid_i);
      end
      else
      begin
        if (issue)
        begin
          fetch_addr_q <= fetch_addr_q + XLEN'(4);
        end
        if (push)
        begin
          resp_addr_q <= resp_addr_q + XLEN'(4);
        end
        if (rvalid_i && (discard_q != '0))
        begin
          discard_q <= discard_q - 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Response FIFO
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      count_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else if (redirect_i)
    begin
      count_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end
    else
    begin
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
      if (push)
      begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop)
      begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (push)
    begin
      instr_mem[wr_ptr_q] <= rdata_i;
      addr_mem[wr_ptr_q]  <= resp_addr_q;
    end
  end

  assign out.valid = (count_q != '0);
  assign out.instr = instr_mem[rd_ptr_q];
  assign out.addr  = addr_mem[rd_ptr_q];

  // Every response must match a granted read
  a_rvalid_outstanding: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid_i |-> (outstanding_q != '0)
  );

  // Request and address held until grant, unless a redirect intervenes
  a_addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    (req_o && !gnt_i) |=> (redirect_i || (req_o && $stable(addr_o)))
  );

endmodule

// ==== fetch_out_if.sv ====
////////////////////////////////////////////////////////////////////////////
// Prefetched instruction path from the prefetch unit into the fetch stage
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface fetch_out_if;
  import fetch_pkg::*;

  // Head entry of the prefetch buffer
  logic            valid;
  logic [XLEN-1:0] instr;
  logic [XLEN-1:0] addr;

  // Stage accepts the head entry
  logic            ready;

  // Transfer on valid && ready, payload held until then
  modport producer (
    output valid,
    output instr,
    output addr,
    input  ready
  );

  modport consumer (
    input  valid,
    input  instr,
    input  addr,
    output ready
  );

endinterface

// ==== fetch_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared widths, mux encodings and the IF/ID register layout of the fetch
// stage. Design files import it inside their module bodies
////////////////////////////////////////////////////////////////////////////

package fetch_pkg;

  // Data and address width
  localparam int XLEN = 32;

  // Prefetch buffer entries, also the limit on outstanding reads
  localparam int PF_DEPTH = 2;

  // Counter width covering 0..PF_DEPTH
  localparam int CNT_W = $clog2(PF_DEPTH + 1);

  // FIFO pointer width
  localparam int PTR_W = (PF_DEPTH > 1) ? $clog2(PF_DEPTH) : 1;

  // addi x0, x0, 0
  localparam logic [XLEN-1:0] INSTR_NOP = 32'h0000_0013;

  // Next-PC source on a redirect
  typedef enum logic [2:0] {
    PC_BOOT      = 3'd0,
    PC_JUMP      = 3'd1,
    PC_EXCEPTION = 3'd2,
    PC_MRET      = 3'd3,
    PC_NMI       = 3'd4
  } pc_mux_e;

  // Trap vector kind, base or vectored interrupt
  typedef enum logic [1:0] {
    EXC_PC_EXCEPTION = 2'd0,
    EXC_PC_IRQ       = 2'd1
  } exc_pc_mux_e;

  // Contents of the IF/ID pipeline register
  typedef struct packed {
    logic            instr_valid;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic            compressed;
    logic            illegal_c;
  } if_id_pipe_t;

endpackage
